/* cache_pkg.sv */
package cache_pkg;

  // Word address split
  localparam int ADR_W      = 21;
  localparam int TAG_W      = 11;
  localparam int INDEX_W    = 8;
  localparam int WSEL_W     = 2;
  localparam int LINE_WORDS = 4;
  localparam int ROWS       = 256;

  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WSEL_W-1:0]  wsel;
  } cache_addr_t;

  // One cache row, 144 bits
  typedef struct packed {
    logic                              valid;
    logic [LINE_WORDS-1:0]             dirty;
    logic [TAG_W-1:0]                  tag;
    logic [LINE_WORDS-1:0][31:0]       words;
  } cache_row_t;

  // Wishbone classic request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    cache_addr_t adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  typedef enum logic [3:0] {
    ST_INIT,
    ST_IDLE,
    ST_LOOKUP,
    ST_HIT,
    ST_DONE,
    ST_MISS,
    ST_FLUSH,
    ST_FILL,
    ST_WRITE_ROW
  } ctrl_state_e;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD,
    OP_MERGE,
    OP_FILL_WORD,
    OP_CLEAN_WORD,
    OP_INVALIDATE
  } line_op_e;

endpackage

/* cache_row_mem.sv */
`timescale 1ns/1ps

module cache_row_mem (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [cache_pkg::INDEX_W-1:0]       index_i,
  input  logic                                we_i,
  input  cache_pkg::cache_row_t               row_i,
  output cache_pkg::cache_row_t               row_o
);

  import cache_pkg::*;

  cache_row_t mem [ROWS];
  cache_row_t row_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[index_i] <= row_i;
    end
  end

  // Write-first, so a lookup right after a row write sees new data
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      row_q <= '0;
    end else if (we_i) begin
      row_q <= row_i;
    end else begin
      row_q <= mem[index_i];
    end
  end

  assign row_o = row_q;

endmodule

/* cache_beat_counter.sv */
`timescale 1ns/1ps

module cache_beat_counter (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          load_i,
  input  logic [cache_pkg::INDEX_W-1:0] value_i,
  input  logic                          step_i,
  output logic [cache_pkg::INDEX_W-1:0] count_o,
  output logic                          last_o
);

  import cache_pkg::*;

  logic [INDEX_W-1:0] count_q;

  // Reset value starts the INIT sweep at the top row
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= INDEX_W'(ROWS - 1);
    end else if (load_i) begin
      count_q <= value_i;
    end else if (step_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;
  assign last_o  = (count_q == '0);

endmodule

/* cache_line_buffer.sv */
`timescale 1ns/1ps

module cache_line_buffer (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  cache_pkg::line_op_e          op_i,
  input  logic [cache_pkg::WSEL_W-1:0] word_i,
  input  cache_pkg::cache_row_t        mem_row_i,
  input  logic [3:0]                   sel_i,
  input  logic [31:0]                  wdat_i,
  input  logic [cache_pkg::TAG_W-1:0]  tag_i,
  input  logic [31:0]                  fill_dat_i,
  output cache_pkg::cache_row_t        row_o,
  output logic [31:0]                  rdat_o
);

  import cache_pkg::*;

  cache_row_t row_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      row_q <= '0;
    end else begin
      case (op_i)
        OP_LOAD: begin
          row_q <= mem_row_i;
        end
        OP_MERGE: begin
          // Byte lanes under the select only
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              row_q.words[word_i][8*b +: 8] <= wdat_i[8*b +: 8];
            end
          end
          row_q.dirty[word_i] <= 1'b1;
        end
        OP_FILL_WORD: begin
          row_q.words[word_i] <= fill_dat_i;
          row_q.dirty[word_i] <= 1'b0;
          row_q.valid         <= 1'b1;
          row_q.tag           <= tag_i;
        end
        OP_CLEAN_WORD: begin
          row_q.dirty[word_i] <= 1'b0;
        end
        OP_INVALIDATE: begin
          row_q.valid <= 1'b0;
        end
        default: begin
          row_q <= row_q;
        end
      endcase
    end
  end

  assign row_o  = row_q;
  assign rdat_o = row_q.words[word_i];

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          s_cyc_i,
  input  logic                          s_stb_i,
  input  logic                          s_we_i,
  input  cache_pkg::cache_addr_t        s_adr_i,
  input  logic                          m_ack_i,
  input  cache_pkg::cache_row_t         row_i,
  input  logic [cache_pkg::INDEX_W-1:0] cnt_i,
  input  logic                          cnt_last_i,
  output cache_pkg::wb_req_t            m_req_o,
  output logic                          s_ack_o,
  output logic [1:0]                    cache_status_o,
  output logic [cache_pkg::INDEX_W-1:0] mem_index_o,
  output logic                          mem_we_o,
  output cache_pkg::line_op_e           line_op_o,
  output logic [cache_pkg::WSEL_W-1:0]  line_word_o,
  output logic                          cnt_load_o,
  output logic [cache_pkg::INDEX_W-1:0] cnt_value_o,
  output logic                          cnt_step_o
);

  import cache_pkg::*;

  ctrl_state_e        state_q, state_d;
  cache_addr_t        req_q;
  logic               we_q;
  logic               loaded_q;
  logic               gap_q;
  logic               hit;
  logic               beat_done;
  logic [WSEL_W-1:0]  beat_word;

  // Count runs 3..0, words go 0..3
  assign beat_word = WSEL_W'(LINE_WORDS - 1) - cnt_i[WSEL_W-1:0];
  assign hit = row_i.valid && (row_i.tag == req_q.tag);

  assign cnt_value_o    = INDEX_W'(LINE_WORDS - 1);
  assign cache_status_o = {state_q == ST_HIT, state_q == ST_MISS};

  always_comb begin
    case (state_q)
      ST_INIT: mem_index_o = cnt_i;
      ST_IDLE: mem_index_o = s_adr_i.index;
      default: mem_index_o = req_q.index;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= ST_INIT;
      req_q    <= '0;
      we_q     <= 1'b0;
      loaded_q <= 1'b0;
      gap_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // One idle cycle on the master bus after every ack
      gap_q   <= m_req_o.cyc && m_ack_i;
      if (state_q == ST_IDLE && s_cyc_i && s_stb_i) begin
        req_q <= s_adr_i;
        we_q  <= s_we_i;
      end
      // First LOOKUP cycle loads the buffer, the second compares
      if (state_q == ST_LOOKUP) begin
        loaded_q <= !loaded_q;
      end
    end
  end

  always_comb begin
    state_d     = state_q;
    m_req_o     = '0;
    m_req_o.sel = 4'hf;
    s_ack_o     = 1'b0;
    mem_we_o    = 1'b0;
    line_op_o   = OP_NONE;
    line_word_o = req_q.wsel;
    cnt_load_o  = 1'b0;
    cnt_step_o  = 1'b0;
    beat_done   = 1'b0;

    case (state_q)
      ST_INIT: begin
        mem_we_o   = 1'b1;
        line_op_o  = OP_INVALIDATE;
        cnt_step_o = 1'b1;
        if (cnt_last_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (s_cyc_i && s_stb_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (!loaded_q) begin
          line_op_o = OP_LOAD;
        end else if (hit) begin
          state_d = ST_HIT;
        end else begin
          state_d = ST_MISS;
        end
      end
      ST_HIT: begin
        s_ack_o = 1'b1;
        if (we_q) begin
          line_op_o = OP_MERGE;
        end
        state_d = ST_DONE;
      end
      ST_DONE: begin
        mem_we_o = we_q;
        state_d  = ST_IDLE;
      end
      ST_MISS: begin
        cnt_load_o = 1'b1;
        if (row_i.valid && (|row_i.dirty)) begin
          state_d = ST_FLUSH;
        end else begin
          state_d = ST_FILL;
        end
      end
      ST_FLUSH: begin
        line_word_o = beat_word;
        if (!gap_q) begin
          if (row_i.dirty[beat_word]) begin
            // Victim address comes from the stored tag
            m_req_o.cyc       = 1'b1;
            m_req_o.stb       = 1'b1;
            m_req_o.we        = 1'b1;
            m_req_o.adr.tag   = row_i.tag;
            m_req_o.adr.index = req_q.index;
            m_req_o.adr.wsel  = beat_word;
            m_req_o.dat       = row_i.words[beat_word];
            if (m_ack_i) begin
              line_op_o = OP_CLEAN_WORD;
              beat_done = 1'b1;
            end
          end else begin
            // Clean word, no bus cycle
            beat_done = 1'b1;
          end
        end
        if (beat_done) begin
          if (cnt_last_i) begin
            cnt_load_o = 1'b1;
            state_d    = ST_FILL;
          end else begin
            cnt_step_o = 1'b1;
          end
        end
      end
      ST_FILL: begin
        line_word_o = beat_word;
        if (!gap_q) begin
          m_req_o.cyc       = 1'b1;
          m_req_o.stb       = 1'b1;
          m_req_o.adr.tag   = req_q.tag;
          m_req_o.adr.index = req_q.index;
          m_req_o.adr.wsel  = beat_word;
          if (m_ack_i) begin
            line_op_o  = OP_FILL_WORD;
            cnt_step_o = !cnt_last_i;
            if (cnt_last_i) begin
              state_d = ST_WRITE_ROW;
            end
          end
        end
      end
      ST_WRITE_ROW: begin
        mem_we_o = 1'b1;
        state_d  = ST_LOOKUP;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        s_cyc_i,
  input  logic                        s_stb_i,
  input  logic                        s_we_i,
  input  logic [cache_pkg::ADR_W-1:0] s_adr_i,
  input  logic [3:0]                  s_sel_i,
  input  logic [31:0]                 s_dat_i,
  output logic [31:0]                 s_dat_o,
  output logic                        s_ack_o,
  output logic [1:0]                  cache_status_o,
  output logic                        m_cyc_o,
  output logic                        m_stb_o,
  output logic                        m_we_o,
  output logic [cache_pkg::ADR_W-1:0] m_adr_o,
  output logic [3:0]                  m_sel_o,
  output logic [31:0]                 m_dat_o,
  input  logic [31:0]                 m_dat_i,
  input  logic                        m_ack_i
);

  import cache_pkg::*;

  cache_addr_t        s_adr;
  wb_req_t            m_req;
  cache_row_t         mem_row;
  cache_row_t         buf_row;
  line_op_e           line_op;
  logic [WSEL_W-1:0]  line_word;
  logic [INDEX_W-1:0] mem_index;
  logic               mem_we;
  logic [INDEX_W-1:0] cnt;
  logic [INDEX_W-1:0] cnt_value;
  logic               cnt_last;
  logic               cnt_load;
  logic               cnt_step;

  assign s_adr   = s_adr_i;
  assign m_cyc_o = m_req.cyc;
  assign m_stb_o = m_req.stb;
  assign m_we_o  = m_req.we;
  assign m_adr_o = m_req.adr;
  assign m_sel_o = m_req.sel;
  assign m_dat_o = m_req.dat;

  cache_ctrl cache_ctrl_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .s_cyc_i        (s_cyc_i),
    .s_stb_i        (s_stb_i),
    .s_we_i         (s_we_i),
    .s_adr_i        (s_adr),
    .m_ack_i        (m_ack_i),
    .row_i          (buf_row),
    .cnt_i          (cnt),
    .cnt_last_i     (cnt_last),
    .m_req_o        (m_req),
    .s_ack_o        (s_ack_o),
    .cache_status_o (cache_status_o),
    .mem_index_o    (mem_index),
    .mem_we_o       (mem_we),
    .line_op_o      (line_op),
    .line_word_o    (line_word),
    .cnt_load_o     (cnt_load),
    .cnt_value_o    (cnt_value),
    .cnt_step_o     (cnt_step)
  );

  cache_beat_counter cache_beat_counter_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .load_i  (cnt_load),
    .value_i (cnt_value),
    .step_i  (cnt_step),
    .count_o (cnt),
    .last_o  (cnt_last)
  );

  cache_line_buffer cache_line_buffer_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op_i       (line_op),
    .word_i     (line_word),
    .mem_row_i  (mem_row),
    .sel_i      (s_sel_i),
    .wdat_i     (s_dat_i),
    .tag_i      (s_adr.tag),
    .fill_dat_i (m_dat_i),
    .row_o      (buf_row),
    .rdat_o     (s_dat_o)
  );

  cache_row_mem cache_row_mem_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .index_i (mem_index),
    .we_i    (mem_we),
    .row_i   (buf_row),
    .row_o   (mem_row)
  );

endmodule

/* tb_cache_checker.sv */
`timescale 1ns/1ps

module tb_cache_checker (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        txn_active_i,
  input  logic                        exp_we_i,
  input  logic [cache_pkg::ADR_W-1:0] exp_adr_i,
  input  logic [31:0]                 exp_word_i,
  input  int                          exp_wb_i,
  input  logic                        ack_i,
  input  logic [31:0]                 rdat_i,
  input  logic [1:0]                  status_i,
  input  logic                        m_cyc_i,
  input  logic                        m_stb_i,
  input  logic                        m_we_i,
  input  logic [cache_pkg::ADR_W-1:0] m_adr_i,
  input  logic [3:0]                  m_sel_i,
  input  logic [31:0]                 m_dat_i,
  input  logic                        m_ack_i,
  output int                          error_count_o
);

  import cache_pkg::*;

  // Processor writes keyed by word address
  logic [31:0]      shadow [int];
  logic [TAG_W-1:0] tag_model [ROWS];
  logic             valid_model [ROWS];
  int               errors;
  int               since_rst;
  int               edges;
  int               reads;
  int               writes;
  logic             saw_miss;

  assign error_count_o = errors;

  initial begin
    errors = 0;
    for (int i = 0; i < ROWS; i++) begin
      valid_model[i] = 1'b0;
    end
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  task automatic check_response();
    cache_addr_t a;
    logic        hit;
    a   = exp_adr_i;
    hit = valid_model[a.index] && (tag_model[a.index] == a.tag);
    if (status_i != 2'b10) begin
      flag_error($sformatf("status %b with s_ack_o at %h", status_i, exp_adr_i));
    end
    if (hit) begin
      if (saw_miss || reads != 0 || writes != 0) begin
        flag_error($sformatf("expected hit at %h but saw a miss or master cycles", exp_adr_i));
      end
      if (edges != 3) begin
        flag_error($sformatf("hit ack %0d cycles after request, expected 3", edges));
      end
    end else begin
      if (!saw_miss) begin
        flag_error($sformatf("no miss flag for %h", exp_adr_i));
      end
      if (reads != LINE_WORDS) begin
        flag_error($sformatf("%0d fill reads for %h, expected 4", reads, exp_adr_i));
      end
    end
    if (writes != exp_wb_i) begin
      flag_error($sformatf("%0d write-backs for %h, expected %0d", writes, exp_adr_i, exp_wb_i));
    end
    if (!exp_we_i && rdat_i != exp_word_i) begin
      flag_error($sformatf("read %h returned %h, expected %h", exp_adr_i, rdat_i, exp_word_i));
    end
    if (exp_we_i) begin
      shadow[int'(exp_adr_i)] = exp_word_i;
    end
    tag_model[a.index]   = a.tag;
    valid_model[a.index] = 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      since_rst <= 0;
      edges     <= 0;
      reads     <= 0;
      writes    <= 0;
      saw_miss  <= 1'b0;
    end else begin
      since_rst <= since_rst + 1;
      if (ack_i && since_rst <= ROWS) begin
        flag_error("s_ack_o during the INIT sweep");
      end
      if (ack_i && !txn_active_i) begin
        flag_error("s_ack_o without a request");
      end
      if (m_cyc_i && m_stb_i && m_ack_i) begin
        if (m_sel_o_bad(m_sel_i)) begin
          flag_error($sformatf("master select %h is not all ones", m_sel_i));
        end
        if (m_we_i) begin
          writes <= writes + 1;
          if (!shadow.exists(int'(m_adr_i)) || shadow[int'(m_adr_i)] != m_dat_i) begin
            flag_error($sformatf("write-back to %h carries %h", m_adr_i, m_dat_i));
          end
        end else begin
          reads <= reads + 1;
        end
      end
      if (!txn_active_i) begin
        edges    <= 0;
        reads    <= 0;
        writes   <= 0;
        saw_miss <= 1'b0;
      end else begin
        edges <= edges + 1;
        if (status_i[0]) begin
          saw_miss <= 1'b1;
        end
        if (ack_i) begin
          check_response();
        end
      end
    end
  end

  function automatic logic m_sel_o_bad(input logic [3:0] sel);
    return sel != 4'hf;
  endfunction

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

  import cache_pkg::*;

  localparam int ACK_LIMIT = 2000;

  logic             clk_i;
  logic             rst_i;
  logic             s_cyc;
  logic             s_stb;
  logic             s_we;
  logic [ADR_W-1:0] s_adr;
  logic [3:0]       s_sel;
  logic [31:0]      s_wdat;
  logic [31:0]      s_rdat;
  logic             s_ack;
  logic [1:0]       status;
  logic             m_cyc;
  logic             m_stb;
  logic             m_we;
  logic [ADR_W-1:0] m_adr;
  logic [3:0]       m_sel;
  logic [31:0]      m_wdat;
  logic [31:0]      m_rdat;
  logic             m_ack;
  logic             txn_active;
  logic             exp_we;
  logic [ADR_W-1:0] exp_adr;
  logic [31:0]      exp_word;
  int               exp_wb;
  int               errors;
  int               timeouts;
  int               requests;
  int               mem_writes;
  int               ack_wait;
  logic [31:0]      backing [int];

  cache_top cache_top_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .s_cyc_i        (s_cyc),
    .s_stb_i        (s_stb),
    .s_we_i         (s_we),
    .s_adr_i        (s_adr),
    .s_sel_i        (s_sel),
    .s_dat_i        (s_wdat),
    .s_dat_o        (s_rdat),
    .s_ack_o        (s_ack),
    .cache_status_o (status),
    .m_cyc_o        (m_cyc),
    .m_stb_o        (m_stb),
    .m_we_o         (m_we),
    .m_adr_o        (m_adr),
    .m_sel_o        (m_sel),
    .m_dat_o        (m_wdat),
    .m_dat_i        (m_rdat),
    .m_ack_i        (m_ack)
  );

  tb_cache_checker checker_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .txn_active_i  (txn_active),
    .exp_we_i      (exp_we),
    .exp_adr_i     (exp_adr),
    .exp_word_i    (exp_word),
    .exp_wb_i      (exp_wb),
    .ack_i         (s_ack),
    .rdat_i        (s_rdat),
    .status_i      (status),
    .m_cyc_i       (m_cyc),
    .m_stb_i       (m_stb),
    .m_we_i        (m_we),
    .m_adr_i       (m_adr),
    .m_sel_i       (m_sel),
    .m_dat_i       (m_wdat),
    .m_ack_i       (m_ack),
    .error_count_o (errors)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] backing_read(input logic [ADR_W-1:0] a);
    if (backing.exists(int'(a))) begin
      return backing[int'(a)];
    end
    return {11'd0, a} ^ 32'hA5A5_0000;
  endfunction

  // Memory model, ack after 0 to 3 wait cycles
  initial begin
    m_ack      = 1'b0;
    m_rdat     = '0;
    mem_writes = 0;
    void'($urandom(32'h089e_261f));
    ack_wait = $urandom_range(3, 0);
    forever begin
      @(negedge clk_i);
      if (m_ack || !(m_cyc && m_stb)) begin
        m_ack = 1'b0;
      end else if (ack_wait > 0) begin
        ack_wait--;
      end else begin
        m_ack    = 1'b1;
        ack_wait = $urandom_range(3, 0);
        if (m_we) begin
          backing[int'(m_adr)] = m_wdat;
          mem_writes++;
        end else begin
          m_rdat = backing_read(m_adr);
        end
      end
    end
  end

  task automatic run_request(input logic we, input logic [ADR_W-1:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat, input logic [31:0] word, input int wb);
    int waited;
    @(negedge clk_i);
    exp_we     = we;
    exp_adr    = adr;
    exp_word   = word;
    exp_wb     = wb;
    s_we       = we;
    s_adr      = adr;
    s_sel      = sel;
    s_wdat     = dat;
    s_cyc      = 1'b1;
    s_stb      = 1'b1;
    txn_active = 1'b1;
    requests++;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!s_ack && waited < ACK_LIMIT);
    if (!s_ack) begin
      $display("Timeout: no s_ack_o within %0d cycles for address %h", ACK_LIMIT, adr);
      timeouts++;
    end
    // Hold through the ack edge, then release
    @(negedge clk_i);
    s_cyc      = 1'b0;
    s_stb      = 1'b0;
    s_we       = 1'b0;
    txn_active = 1'b0;
  endtask

  initial begin
    int          fd;
    string       line;
    int          op;
    logic [31:0] adr;
    logic [31:0] sel;
    logic [31:0] dat;
    logic [31:0] word;
    int          wb;
    rst_i      = 1'b1;
    s_cyc      = 1'b0;
    s_stb      = 1'b0;
    s_we       = 1'b0;
    s_adr      = '0;
    s_sel      = '0;
    s_wdat     = '0;
    txn_active = 1'b0;
    exp_we     = 1'b0;
    exp_adr    = '0;
    exp_word   = '0;
    exp_wb     = 0;
    timeouts   = 0;
    requests   = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    fd = $fopen("cache_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open cache_input.txt");
    end
    while (fd != 0 && timeouts == 0 && !$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.getc(0) != "#" &&
          $sscanf(line, "%d %h %h %h %h %d", op, adr, sel, dat, word, wb) == 6) begin
        run_request(op == 1, adr[ADR_W-1:0], sel[3:0], dat, word, wb);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (4) @(negedge clk_i);
    $display("Summary: %0d requests, %0d check errors, %0d timeouts, %0d memory writes",
             requests, errors, timeouts, mem_writes);
    if (fd != 0 && requests > 0 && errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* cache_input.txt */
# op (0 read, 1 write) word_addr sel data word writebacks
# word is the value read back, or for a write the merged word
0 000448 f 00000000 a5a50448 0
0 000449 f 00000000 a5a50449 0
0 00044b f 00000000 a5a5044b 0
1 000449 3 11223344 a5a53344 0
0 000449 f 00000000 a5a53344 0
1 00044b f deadbeef deadbeef 0
1 00044b 8 77000000 77adbeef 0
0 00044b f 00000000 77adbeef 0
# same index, other tag, evicts two dirty words
0 00084a f 00000000 a5a5084a 2
0 000449 f 00000000 a5a53344 0
0 00044b f 00000000 77adbeef 0
0 000448 f 00000000 a5a50448 0
# write miss
1 0014c3 1 000000ab a5a514ab 0
0 0014c1 f 00000000 a5a514c1 0
0 0014c3 f 00000000 a5a514ab 0
0 1ffcc0 f 00000000 a5bafcc0 1
0 0014c3 f 00000000 a5a514ab 0
1 0014c0 6 00556600 a55566c0 0
0 0014c0 f 00000000 a55566c0 0
# first and last rows
0 000000 f 00000000 a5a50000 0
0 0fffff f 00000000 a5aaffff 0
1 0fffff f 0badf00d 0badf00d 0
0 0003ff f 00000000 a5a503ff 1
0 0fffff f 00000000 0badf00d 0

/* vlog.f */
cache_pkg.sv
cache_row_mem.sv
cache_beat_counter.sv
cache_line_buffer.sv
cache_ctrl.sv
cache_top.sv
tb_cache_checker.sv
tb_cache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_cache -f vlog.f || exit 1
out="$(./obj_dir/Vtb_cache)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
